/* compile.f */
verilog/cache_pkg.sv
verilog/wb_pkg.sv
verilog/cache_ram.sv
verilog/word_lane.sv
verilog/line_buffer.sv
verilog/wb_master.sv
verilog/cache_ctrl.sv
verilog/dcache_top.sv
tests/tb_wb_mem.sv
tests/dcache_assertions.sv
tests/tb_dcache.sv

/* run.sh */
#!/bin/bash
# Build the data cache testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_dcache -f compile.f -o sim_dcache \
        && ./obj_dir/sim_dcache > sim.log 2>&1 \
        || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tests/tb_dcache.sv */
// --------------------
// Data cache testbench
// Bypass, fill, hit and write-back checks against a shadow memory
// --------------------

`timescale 1ns/1ps
`default_nettype none

module tb_dcache
        import cache_pkg::*;
        import wb_pkg::*;
;

localparam int LINE_BYTES = 16;
localparam int NUM_LINES  = 16;
localparam int WORDS      = LINE_BYTES / 4;
localparam int MAX_WAIT   = 3;
localparam int MEM_WORDS  = 256;
localparam int CLK_NS     = 4;
localparam int N_BYPASS   = 40;
localparam int N_FIRST    = 8;
localparam int N_WB       = 4;
localparam int N_RAND     = 300;
localparam int TOTAL_OPS  = N_BYPASS + 2 * N_FIRST + 3 * N_WB + N_RAND;
// Worst case per op is a write-back plus a fill plus margin
localparam int OP_CYCLES  = 2 * WORDS * (MAX_WAIT + 2) + 8;

logic           i_clk;
logic           i_reset;
logic           i_rd;
logic           i_wr;
word_t          i_addr;
word_t          i_din;
ben_t           i_ben;
logic           i_cache_en;
word_t          o_dat;
logic           o_ack;
logic           wb_cyc;
logic           wb_stb;
logic [31:0]    wb_adr;
word_t          wb_dat_w;
ben_t           wb_sel;
logic           wb_we;
cti_t           wb_cti;
logic           wb_ack;
word_t          wb_dat_r;

integer         seed;
int             errors;
int             checks;
int             bus_beats;
int             classic_cnt;
int             burst_cnt;
int             burst_pos;
logic [31:0]    last_classic_adr;
word_t          shadow [MEM_WORDS];

dcache_top #(.LINE_BYTES(LINE_BYTES), .NUM_LINES(NUM_LINES)) i_dcache_top (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_rd(i_rd), .i_wr(i_wr), .i_addr(i_addr), .i_din(i_din), .i_ben(i_ben),
        .i_cache_en(i_cache_en), .o_dat(o_dat), .o_ack(o_ack),
        .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_adr(wb_adr), .o_wb_dat(wb_dat_w),
        .o_wb_sel(wb_sel), .o_wb_we(wb_we), .o_wb_cti(wb_cti),
        .i_wb_ack(wb_ack), .i_wb_dat(wb_dat_r)
);

tb_wb_mem #(.MAX_WAIT(MAX_WAIT), .MEM_WORDS(MEM_WORDS)) u_mem (
        .i_clk(i_clk), .i_reset(i_reset), .i_cyc(wb_cyc), .i_stb(wb_stb),
        .i_we(wb_we), .i_adr(wb_adr), .i_dat(wb_dat_w), .i_sel(wb_sel),
        .o_ack(wb_ack), .o_dat(wb_dat_r)
);

initial
begin
        i_clk = 1'b0;
        forever #(CLK_NS / 2) i_clk = ~i_clk;
end

// --------------------
// Reference model
// --------------------

function automatic word_t pattern_word(input int w);
        logic [7:0] a;
        a = w[7:0];
        return {a ^ 8'h5a, 8'hc3, ~a, a * 8'd7};
endfunction

function automatic word_t ref_read(input word_t addr);
        return shadow[int'(addr[9:2])];
endfunction

task automatic shadow_write(input word_t addr, input word_t din, input ben_t ben);
        for (int b = 0; b < 4; b++)
                if (ben[b])
                        shadow[int'(addr[9:2])][b*8 +: 8] = din[b*8 +: 8];
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
                errors++;
                $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
endtask

// Request held until ack and dropped one edge later
task automatic access(input logic wr, input word_t addr, input word_t din, input ben_t ben);
        word_t rdat;
        i_rd   = !wr;
        i_wr   = wr;
        i_addr = addr;
        i_din  = din;
        i_ben  = ben;
        @(negedge i_clk);
        while (!o_ack)
                @(negedge i_clk);
        rdat = o_dat;
        @(posedge i_clk);
        #1;
        i_rd = 1'b0;
        i_wr = 1'b0;
        if (wr)
                shadow_write(addr, din, ben);
        else
                check("o_dat", rdat, ref_read(addr));
endtask

// Bus monitor counts beats and checks burst framing
always @(negedge i_clk)
begin
        if (!i_reset && wb_cyc && wb_stb && wb_ack)
        begin
                bus_beats++;
                case (wb_cti)
                CTI_CLASSIC:
                begin
                        if (burst_pos != 0)
                        begin
                                errors++;
                                $display("Classic cycle inside a burst at %0t", $time);
                        end
                        classic_cnt++;
                        last_classic_adr = wb_adr;
                end
                CTI_BURST:
                begin
                        if (burst_pos >= WORDS - 1)
                        begin
                                errors++;
                                $display("Burst longer than a line at %0t", $time);
                        end
                        burst_pos++;
                end
                CTI_EOB:
                begin
                        if (burst_pos != WORDS - 1)
                        begin
                                errors++;
                                $display("Burst ended after %0d beats at %0t", burst_pos + 1, $time);
                        end
                        burst_pos = 0;
                        burst_cnt++;
                end
                default:
                begin
                        errors++;
                        $display("Unknown cycle type %b at %0t", wb_cti, $time);
                end
                endcase
        end
end

initial
begin
        #(TOTAL_OPS * OP_CYCLES * CLK_NS + 100 * CLK_NS);
        $display("Watchdog expired, simulation did not finish in time");
        $display("ERRORS FOUND");
        $finish;
end

// --------------------
// Stimulus
// --------------------

initial
begin
        word_t  a;
        word_t  d;
        word_t  r;
        int     beats0;
        int     classic0;
        int     bursts0;

        seed = 32'h93f80136;
        errors = 0;
        checks = 0;
        bus_beats = 0;
        classic_cnt = 0;
        burst_cnt = 0;
        burst_pos = 0;
        last_classic_adr = '0;
        i_reset = 1'b1;
        i_rd = 1'b0;
        i_wr = 1'b0;
        i_addr = '0;
        i_din = '0;
        i_ben = '0;
        i_cache_en = 1'b0;
        for (int w = 0; w < MEM_WORDS; w++)
                shadow[w] = pattern_word(w);

        repeat (2) @(posedge i_clk);
        #1 i_reset = 1'b0;

        // Idle after reset
        repeat (10)
        begin
                @(negedge i_clk);
                check("o_ack", o_ack, 1'b0);
                check("o_wb_cyc", wb_cyc, 1'b0);
        end
        @(posedge i_clk);
        #1;

        // Bypass gives one classic cycle per access
        for (int n = 0; n < N_BYPASS; n++)
        begin
                r = $random(seed);
                a = {22'd0, 2'b11, r[5:0], 2'b00};
                d = $random(seed);
                beats0 = bus_beats;
                classic0 = classic_cnt;
                access(r[8], a, d, r[15:12]);
                check("classic cycles", classic_cnt, classic0 + 1);
                check("bus beats", bus_beats, beats0 + 1);
                check("o_wb_adr", last_classic_adr, a);
                if (r[8])
                        check("memory word", u_mem.mem[int'(a[9:2])], ref_read(a));
        end

        // First reads come from memory and repeat reads hit
        i_cache_en = 1'b1;
        for (int n = 0; n < N_FIRST; n++)
        begin
                a = 32'(n * 32 + 4 * (n % WORDS));
                access(1'b0, a, '0, '0);
                beats0 = bus_beats;
                access(1'b0, a, '0, '0);
                check("bus beats on hit", bus_beats, beats0);
                check("o_wb_cyc on hit", wb_cyc, 1'b0);
        end

        // Dirty line pushed out by a conflicting line
        for (int n = 0; n < N_WB; n++)
        begin
                a = 32'(n * 64 + 4);
                d = $random(seed);
                bursts0 = burst_cnt;
                access(1'b1, a, d, 4'b1111);
                access(1'b0, a + 32'h100, '0, '0);
                check("memory after write-back", u_mem.mem[int'(a[9:2])], ref_read(a));
                check("bursts for write-back", burst_cnt, bursts0 + 2);
                access(1'b0, a, '0, '0);
        end

        // Random mix over a 1 KB region
        for (int n = 0; n < N_RAND; n++)
        begin
                r = $random(seed);
                a = {22'd0, r[7:0], 2'b00};
                d = $random(seed);
                access(r[9], a, d, r[19:16]);
        end

        repeat (4) @(posedge i_clk);
        $display("Checks: %0d  errors: %0d  bursts: %0d", checks, errors, burst_cnt);
        if (errors == 0)
                $display("NO ERRORS");
        else
                $display("ERRORS FOUND");
        $finish;
end

endmodule

`default_nettype wire

/* tests/dcache_assertions.sv */
// --------------------
// Data cache assertions
// Bus protocol and processor ack rules
// --------------------

`timescale 1ns/1ps
`default_nettype none

module dcache_assertions
        import wb_pkg::*;
(
        input  wire logic               i_clk,
        input  wire logic               i_reset,
        input  wire logic               i_ack,
        input  wire logic               i_wb_cyc,
        input  wire logic               i_wb_stb,
        input  wire logic [31:0]        i_wb_adr,
        input  wire logic [31:0]        i_wb_dat,
        input  wire logic [2:0]         i_wb_cti,
        input  wire logic               i_wb_ack
);

stb_in_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_stb |-> i_wb_cyc)
        else $error("stb high outside a bus cycle");

// Held until the slave acks
stb_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_wb_stb && !i_wb_ack) |=> ($stable(i_wb_adr) && $stable(i_wb_dat)))
        else $error("address or data changed while waiting for ack");

no_ack_in_reset: assert property (@(posedge i_clk)
        (i_reset || $past(i_reset)) |-> !i_ack)
        else $error("processor ack during or right after reset");

burst_adr_step: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_wb_stb && i_wb_ack && i_wb_cti == CTI_BURST) |=> i_wb_adr == $past(i_wb_adr) + 32'd4)
        else $error("burst address did not step by one word");

endmodule

bind dcache_top dcache_assertions u_assertions (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_ack          (o_ack),
        .i_wb_cyc       (o_wb_cyc),
        .i_wb_stb       (o_wb_stb),
        .i_wb_adr       (o_wb_adr),
        .i_wb_dat       (o_wb_dat),
        .i_wb_cti       (o_wb_cti),
        .i_wb_ack       (i_wb_ack)
);

`default_nettype wire

/* tests/tb_wb_mem.sv */
// --------------------
// Wishbone slave memory model
// Random wait states, byte-enable writes
// --------------------

`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem #(
        parameter int           MAX_WAIT  = 3,
        parameter int           MEM_WORDS = 256,
        parameter logic [31:0]  SEED      = 32'h93f80136
)
(
        input  wire logic               i_clk,
        input  wire logic               i_reset,
        input  wire logic               i_cyc,
        input  wire logic               i_stb,
        input  wire logic               i_we,
        input  wire logic [31:0]        i_adr,
        input  wire logic [31:0]        i_dat,
        input  wire logic [3:0]         i_sel,
        output logic                    o_ack,
        output logic [31:0]             o_dat
);

logic [31:0]    mem [MEM_WORDS];
integer         seed;
int             wait_cnt;
int             idx;

// Known fill, built from the full word index
function automatic logic [31:0] init_word(input int w);
        logic [7:0] a;
        a = w[7:0];
        return {a ^ 8'h5a, 8'hc3, ~a, a * 8'd7};
endfunction

initial
begin
        seed     = SEED;
        wait_cnt = 0;
        o_ack    = 1'b0;
        o_dat    = '0;
        for (int w = 0; w < MEM_WORDS; w++)
                mem[w] = init_word(w);
end

assign idx = int'(i_adr[9:2]);

always @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_ack <= 1'b0;
        end
        else if (i_cyc && i_stb && !o_ack)
        begin
                if (wait_cnt == 0)
                begin
                        o_ack    <= 1'b1;
                        o_dat    <= mem[idx];
                        wait_cnt <= int'({$random(seed)} % (MAX_WAIT + 1));
                        if (i_we)
                        begin
                                for (int b = 0; b < 4; b++)
                                        if (i_sel[b])
                                                mem[idx][b*8 +: 8] <= i_dat[b*8 +: 8];
                        end
                end
                else
                begin
                        wait_cnt <= wait_cnt - 1;       // Wait state
                end
        end
        else
        begin
                o_ack <= 1'b0;
        end
end

endmodule

`default_nettype wire

/* verilog/dcache_top.sv */
// --------------------
// Data cache top level
// Write-back direct-mapped cache on Wishbone
// --------------------

`timescale 1ns/1ps
`default_nettype none

module dcache_top
        import cache_pkg::*;
        import wb_pkg::*;
#(
        parameter int   LINE_BYTES = 16,
        parameter int   NUM_LINES  = 16
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        // Processor port
        input  logic                    i_rd,
        input  logic                    i_wr,
        input  word_t                   i_addr,
        input  word_t                   i_din,
        input  ben_t                    i_ben,
        input  logic                    i_cache_en,
        output word_t                   o_dat,
        output logic                    o_ack,

        // Wishbone
        output logic                    o_wb_cyc,
        output logic                    o_wb_stb,
        output logic [WB_ADR_W-1:0]     o_wb_adr,
        output word_t                   o_wb_dat,
        output ben_t                    o_wb_sel,
        output logic                    o_wb_we,
        output cti_t                    o_wb_cti,
        input  logic                    i_wb_ack,
        input  word_t                   i_wb_dat
);

localparam int OFF_W  = $clog2(LINE_BYTES);
localparam int IDX_W  = $clog2(NUM_LINES);
localparam int TAG_W  = 32 - OFF_W - IDX_W;
localparam int BEAT_W = $clog2(LINE_BYTES / WORD_BYTES);

typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [TAG_W-1:0]       tag;
} tag_entry_t;

typedef logic [LINE_BYTES*8-1:0] line_t;

tag_entry_t             tag_rd;
tag_entry_t             tag_wr;
line_t                  data_rd;
line_t                  data_wr;
line_t                  fill_line;
line_t                  merged_line;
word_t                  lane_word;
word_t                  wb_word;
logic [IDX_W-1:0]       index;

logic                   bypass_sel;
logic                   tag_we;
logic                   tag_dirty;
logic                   data_we;
logic                   fill_sel;
logic                   start_burst;
logic                   start_single;
logic                   burst_we;
logic [WB_ADR_W-1:0]    burst_adr;
logic                   beat;
logic [BEAT_W-1:0]      beat_idx;
logic                   done;

assign index   = i_addr[OFF_W +: IDX_W];
assign tag_wr  = '{valid: 1'b1, dirty: tag_dirty, tag: i_addr[31 -: TAG_W]};
assign data_wr = fill_sel ? fill_line : merged_line;
assign o_dat   = bypass_sel ? i_wb_dat : lane_word;

cache_ctrl #(.LINE_BYTES(LINE_BYTES), .NUM_LINES(NUM_LINES)) u_ctrl (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rd           (i_rd),
        .i_wr           (i_wr),
        .i_addr         (i_addr),
        .i_cache_en     (i_cache_en),
        .o_ack          (o_ack),
        .o_bypass_sel   (bypass_sel),
        .i_tag_valid    (tag_rd.valid),
        .i_tag_dirty    (tag_rd.dirty),
        .i_tag          (tag_rd.tag),
        .o_tag_we       (tag_we),
        .o_tag_dirty    (tag_dirty),
        .o_data_we      (data_we),
        .o_fill_sel     (fill_sel),
        .i_done         (done),
        .o_start_burst  (start_burst),
        .o_start_single (start_single),
        .o_burst_we     (burst_we),
        .o_burst_adr    (burst_adr)
);

wb_master #(.LINE_BYTES(LINE_BYTES)) u_wb_master (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_start_burst  (start_burst),
        .i_start_single (start_single),
        .i_we           (burst_we),
        .i_adr          (burst_adr),
        .i_single_dat   (i_din),
        .i_burst_dat    (wb_word),
        .i_sel          (i_ben),
        .o_wb_cyc       (o_wb_cyc),
        .o_wb_stb       (o_wb_stb),
        .o_wb_we        (o_wb_we),
        .o_wb_adr       (o_wb_adr),
        .o_wb_dat       (o_wb_dat),
        .o_wb_sel       (o_wb_sel),
        .o_wb_cti       (o_wb_cti),
        .i_wb_ack       (i_wb_ack),
        .o_beat         (beat),
        .o_beat_idx     (beat_idx),
        .o_done         (done)
);

line_buffer #(.LINE_BYTES(LINE_BYTES)) u_line_buffer (
        .i_clk          (i_clk),
        .i_beat         (beat),
        .i_beat_idx     (beat_idx),
        .i_wb_dat       (i_wb_dat),
        .i_victim_line  (data_rd),
        .o_fill_line    (fill_line),
        .o_wb_word      (wb_word)
);

word_lane #(.LINE_BYTES(LINE_BYTES)) u_word_lane (
        .i_line         (data_rd),
        .i_addr         (i_addr),
        .i_din          (i_din),
        .i_ben          (i_ben),
        .o_word         (lane_word),
        .o_merged_line  (merged_line)
);

// Tag array, cleared on reset
cache_ram #(
        .T_ENTRY        (tag_entry_t),
        .NUM_LINES      (NUM_LINES),
        .CLEAR_ON_RESET (1'b1)
) u_tag_ram (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_index        (index),
        .i_we           (tag_we),
        .i_wdata        (tag_wr),
        .o_rdata        (tag_rd)
);

cache_ram #(
        .T_ENTRY        (line_t),
        .NUM_LINES      (NUM_LINES),
        .CLEAR_ON_RESET (1'b0)
) u_data_ram (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_index        (index),
        .i_we           (data_we),
        .i_wdata        (data_wr),
        .o_rdata        (data_rd)
);

endmodule

`default_nettype wire

/* verilog/cache_ctrl.sv */
// --------------------
// Data cache controller
// Lookup, write-back, fill and bypass sequencing
// --------------------

`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
        import cache_pkg::*;
        import wb_pkg::*;
#(
        parameter int   LINE_BYTES = 16,
        parameter int   NUM_LINES  = 16,
        localparam int  OFF_W      = $clog2(LINE_BYTES),
        localparam int  IDX_W      = $clog2(NUM_LINES),
        localparam int  TAG_W      = 32 - OFF_W - IDX_W
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  logic                    i_rd,
        input  logic                    i_wr,
        input  word_t                   i_addr,
        input  logic                    i_cache_en,
        output logic                    o_ack,
        output logic                    o_bypass_sel,   // o_dat from the bus

        input  logic                    i_tag_valid,
        input  logic                    i_tag_dirty,
        input  logic [TAG_W-1:0]        i_tag,
        output logic                    o_tag_we,
        output logic                    o_tag_dirty,
        output logic                    o_data_we,
        output logic                    o_fill_sel,     // Fill line, else merged line

        input  logic                    i_done,
        output logic                    o_start_burst,
        output logic                    o_start_single,
        output logic                    o_burst_we,
        output logic [WB_ADR_W-1:0]     o_burst_adr     // Bus start address
);

ctrl_state_t            state_q;
ctrl_state_t            state_d;
logic                   fill_kick_q;    // Fill start after a write-back
logic                   req;
logic                   hit;
logic [WB_ADR_W-1:0]    req_line_adr;
logic [WB_ADR_W-1:0]    victim_adr;

assign req          = i_rd | i_wr;
assign hit          = i_tag_valid && (i_tag == i_addr[31 -: TAG_W]);
assign req_line_adr = {i_addr[31:OFF_W], {OFF_W{1'b0}}};
assign victim_adr   = {i_tag, i_addr[OFF_W +: IDX_W], {OFF_W{1'b0}}};
assign o_bypass_sel = (state_q == BYPASS);

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_q     <= IDLE;
                fill_kick_q <= 1'b0;
        end
        else
        begin
                state_q     <= state_d;
                fill_kick_q <= (state_q == WRITEBACK) && i_done;
        end
end

// --------------------
// Next state and strobes
// --------------------

always_comb
begin
        state_d        = state_q;
        o_ack          = 1'b0;
        o_tag_we       = 1'b0;
        o_tag_dirty    = 1'b0;
        o_data_we      = 1'b0;
        o_fill_sel     = 1'b0;
        o_start_burst  = fill_kick_q;   // Fill burst in first FILL cycle
        o_start_single = 1'b0;
        o_burst_we     = 1'b0;
        o_burst_adr    = req_line_adr;

        case (state_q)
        IDLE:
        begin
                if (req && !i_cache_en)
                begin
                        // Uncached, one classic cycle at the request address
                        o_start_single = 1'b1;
                        o_burst_we     = i_wr;
                        o_burst_adr    = i_addr;
                        state_d        = BYPASS;
                end
                else if (req && hit)
                begin
                        o_ack       = 1'b1;
                        o_tag_we    = i_wr;
                        o_data_we   = i_wr;
                        o_tag_dirty = 1'b1;
                end
                else if (req && i_tag_valid && i_tag_dirty)
                begin
                        o_start_burst = 1'b1;
                        o_burst_we    = 1'b1;
                        o_burst_adr   = victim_adr;
                        state_d       = WRITEBACK;
                end
                else if (req)
                begin
                        o_start_burst = 1'b1;
                        state_d       = FILL;
                end
        end

        BYPASS:
        begin
                o_ack = i_done;         // Ack rides on the bus ack
                if (i_done)
                        state_d = IDLE;
        end

        WRITEBACK:
        begin
                if (i_done)
                        state_d = FILL;
        end

        FILL:
        begin
                if (i_done)
                        state_d = UPDATE;
        end

        UPDATE:
        begin
                // Valid and clean, lookup retried from IDLE
                o_tag_we   = 1'b1;
                o_data_we  = 1'b1;
                o_fill_sel = 1'b1;
                state_d    = IDLE;
        end

        default:
                state_d = IDLE;
        endcase
end

endmodule

`default_nettype wire

/* verilog/wb_master.sv */
// --------------------
// Wishbone master
// Single accesses and incrementing bursts
// --------------------

`timescale 1ns/1ps
`default_nettype none

module wb_master
        import cache_pkg::*;
        import wb_pkg::*;
#(
        parameter int   LINE_BYTES = 16,
        localparam int  WORDS      = LINE_BYTES / WORD_BYTES,
        localparam int  BEAT_W     = $clog2(WORDS)
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  logic                    i_start_burst,
        input  logic                    i_start_single,
        input  logic                    i_we,
        input  logic [WB_ADR_W-1:0]     i_adr,
        input  word_t                   i_single_dat,
        input  word_t                   i_burst_dat,
        input  ben_t                    i_sel,

        output logic                    o_wb_cyc,
        output logic                    o_wb_stb,
        output logic                    o_wb_we,
        output logic [WB_ADR_W-1:0]     o_wb_adr,
        output word_t                   o_wb_dat,
        output ben_t                    o_wb_sel,
        output cti_t                    o_wb_cti,
        input  logic                    i_wb_ack,

        output logic                    o_beat,
        output logic [BEAT_W-1:0]       o_beat_idx,
        output logic                    o_done
);

logic [BEAT_W-1:0]      cnt_q;          // Word of the pending beat
logic                   single_q;
logic                   last;

assign o_beat     = o_wb_stb & i_wb_ack;
assign last       = single_q || (cnt_q == BEAT_W'(WORDS - 1));
assign o_done     = o_beat & last;
assign o_beat_idx = cnt_q;

// --------------------
// Cycle control
// --------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                cnt_q    <= '0;
                single_q <= 1'b0;
        end
        else if (i_start_burst || i_start_single)
        begin
                o_wb_cyc <= 1'b1;
                o_wb_stb <= 1'b1;
                cnt_q    <= '0;
                single_q <= i_start_single;
        end
        else if (o_beat)
        begin
                if (last)
                begin
                        o_wb_cyc <= 1'b0;       // Cycle ends at the last ack
                        o_wb_stb <= 1'b0;
                        cnt_q    <= '0;
                end
                else
                begin
                        cnt_q <= cnt_q + 1'b1;
                end
        end
end

// Address, data and cycle type of each beat
always_ff @(posedge i_clk)
begin
        if (i_start_single)
        begin
                o_wb_adr <= i_adr;
                o_wb_dat <= i_single_dat;
                o_wb_sel <= i_sel;
                o_wb_we  <= i_we;
                o_wb_cti <= CTI_CLASSIC;
        end
        else if (i_start_burst)
        begin
                o_wb_adr <= i_adr;
                o_wb_dat <= i_burst_dat;
                o_wb_sel <= '1;                 // Whole words
                o_wb_we  <= i_we;
                o_wb_cti <= CTI_BURST;
        end
        else if (o_beat && !last)
        begin
                o_wb_adr <= o_wb_adr + WB_ADR_W'(WORD_BYTES);
                o_wb_dat <= i_burst_dat;
                o_wb_cti <= (cnt_q == BEAT_W'(WORDS - 2)) ? CTI_EOB : CTI_BURST;
        end
end

endmodule

`default_nettype wire

/* verilog/line_buffer.sv */
// --------------------
// Line buffer
// Collects fill beats, feeds write-back words
// --------------------

`timescale 1ns/1ps
`default_nettype none

module line_buffer
        import cache_pkg::*;
#(
        parameter int   LINE_BYTES = 16,
        localparam int  WORDS      = LINE_BYTES / WORD_BYTES,
        localparam int  BEAT_W     = $clog2(WORDS)
)
(
        input  logic                            i_clk,
        input  logic                            i_beat,
        input  logic [BEAT_W-1:0]               i_beat_idx,
        input  word_t                           i_wb_dat,
        input  logic [LINE_BYTES*8-1:0]         i_victim_line,
        output logic [LINE_BYTES*8-1:0]         o_fill_line,
        output word_t                           o_wb_word
);

word_t                  buf_q [WORDS];
logic [BEAT_W-1:0]      wb_idx;

always_ff @(posedge i_clk)
begin
        if (i_beat)
                buf_q[i_beat_idx] <= i_wb_dat;
end

always_comb
begin
        for (int w = 0; w < WORDS; w++)
                o_fill_line[w*32 +: 32] = buf_q[w];
end

// On a beat the master loads the word after the current one
assign wb_idx    = i_beat ? i_beat_idx + 1'b1 : i_beat_idx;
assign o_wb_word = i_victim_line[{wb_idx, 5'd0} +: 32];

endmodule

`default_nettype wire

/* verilog/word_lane.sv */
// --------------------
// Word lane
// Word select and byte-enable merge
// --------------------

`timescale 1ns/1ps
`default_nettype none

module word_lane
        import cache_pkg::*;
#(
        parameter int   LINE_BYTES = 16,
        localparam int  WORDS      = LINE_BYTES / WORD_BYTES,
        localparam int  SEL_W      = $clog2(WORDS)
)
(
        input  logic [LINE_BYTES*8-1:0]         i_line,
        input  word_t                           i_addr,
        input  word_t                           i_din,
        input  ben_t                            i_ben,
        output word_t                           o_word,
        output logic [LINE_BYTES*8-1:0]         o_merged_line
);

logic [SEL_W-1:0] off;

assign off    = i_addr[2 +: SEL_W];     // Word offset in the line
assign o_word = i_line[{off, 5'd0} +: 32];

always_comb
begin
        o_merged_line = i_line;
        for (int w = 0; w < WORDS; w++)
        begin
                for (int b = 0; b < WORD_BYTES; b++)
                begin
                        if ((SEL_W'(w) == off) && i_ben[b])
                                o_merged_line[w*32 + b*8 +: 8] = i_din[b*8 +: 8];
                end
        end
end

endmodule

`default_nettype wire

/* verilog/cache_ram.sv */
// --------------------
// Cache array
// Async read, clocked write, optional clear
// --------------------

`timescale 1ns/1ps
`default_nettype none

module cache_ram
        import cache_pkg::*;
#(
        parameter type  T_ENTRY        = word_t,
        parameter int   NUM_LINES      = 16,
        parameter bit   CLEAR_ON_RESET = 1'b0
)
(
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic [$clog2(NUM_LINES)-1:0]    i_index,
        input  logic                            i_we,
        input  T_ENTRY                          i_wdata,
        output T_ENTRY                          o_rdata
);

T_ENTRY mem [NUM_LINES];

always_ff @(posedge i_clk)
begin
        if (CLEAR_ON_RESET && i_reset)
        begin
                for (int i = 0; i < NUM_LINES; i++)
                        mem[i] <= '0;   // Drops every valid bit
        end
        else if (i_we)
        begin
                mem[i_index] <= i_wdata;
        end
end

assign o_rdata = mem[i_index];

endmodule

`default_nettype wire

/* verilog/wb_pkg.sv */
// --------------------
// Wishbone definitions
// Cycle type codes and bus widths
// --------------------

`default_nettype none

package wb_pkg;

        localparam int WB_ADR_W = 32;

        // Cycle type indicator
        typedef logic [2:0] cti_t;

        localparam cti_t CTI_CLASSIC = 3'b000;
        localparam cti_t CTI_BURST   = 3'b010;  // Incrementing burst
        localparam cti_t CTI_EOB     = 3'b111;  // Last beat of a burst

endpackage

`default_nettype wire

/* verilog/cache_pkg.sv */
// --------------------
// Cache core types
// Processor word types and controller state encoding
// --------------------

`default_nettype none

package cache_pkg;

        // Processor word and its byte enables
        typedef logic [31:0] word_t;
        typedef logic [3:0]  ben_t;

        localparam int WORD_BYTES = 4;

        // Controller states
        typedef enum logic [2:0] {
                IDLE      = 3'd0,       // Lookup, hits ack here
                BYPASS    = 3'd1,       // Single uncached access
                WRITEBACK = 3'd2,       // Victim line burst out
                FILL      = 3'd3,       // Line burst in
                UPDATE    = 3'd4        // Arrays written after fill
        } ctrl_state_t;

endpackage

`default_nettype wire
